// File: list.f
+incdir+rtl
rtl/stream_drain_pkg.sv
rtl/counter_bin.sv
rtl/fifo_control.sv
rtl/stream_drain_ctrl.sv
rtl/beat_buffer.sv
rtl/burst_issuer.sv
rtl/stream_drain_top.sv
verification/tb_stream_drain.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the stream drain testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_stream_drain -f list.f || exit 1
sim_out=$(./obj_dir/Vtb_stream_drain 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qF "All tests passed!" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: verification/tb_stream_drain.sv
`include "stream_drain_consts.svh"

module tb_stream_drain
        import stream_drain_pkg::*;
();

        localparam int AW            = $clog2(`DRAIN_DEPTH);
        localparam int LW            = `DRAIN_LEN_W;
        localparam int PHASE_CYCLES  = 160;
        localparam int BP_CYCLES     = 40;     // Output held off until the buffer fills
        localparam int PLANNED_BEATS = 4 * PHASE_CYCLES + BP_CYCLES;
        localparam int WATCHDOG_TIME = (40 * PLANNED_BEATS + 10) * 100;

        logic          axi_aclk = 1'b0;
        logic          arst_n;
        logic [LW-1:0] burst_len;
        logic          in_valid;
        beat_t         in_beat;
        logic          in_ready;
        logic          cmd_valid;
        burst_cmd_t    cmd;
        logic          out_valid;
        beat_t         out_beat;
        logic          out_last;
        logic          out_ready;
        drain_status_t status;

        // Reference model state
        logic [AW:0]   exp_avail;              // Unreserved beats
        logic [AW:0]   exp_stored;             // Beats held in the buffer
        logic [LW-1:0] exp_remaining;          // Beats left in open burst
        logic [31:0]   exp_head;
        logic [31:0]   accept_count;
        logic [31:0]   accepted_q[$];
        logic          stall_prev;
        beat_t         beat_prev;
        logic          saw_full;
        logic          reset_seen = 1'b0;      // Reset edge has loaded the DUT
        logic [31:0]   lcg_state = 32'hd92ce453;

        stream_drain_top dut (.*);

        always #50 axi_aclk = ~axi_aclk;

        // ------------------------------
        // Helpers
        // ------------------------------
        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic roll_percent(input int pct, output logic hit);
                lcg_state = lcg_next(lcg_state);
                hit = (lcg_state[31:16] % 16'd100) < 16'(pct);      // Upper bits are the better ones
        endtask

        // {full, almost_full, empty, almost_empty} for a given count
        function automatic logic [3:0] flags_for(input logic [AW:0] n);
                return {n == (AW+1)'(`DRAIN_DEPTH),
                        n >= (AW+1)'(`DRAIN_DEPTH - `DRAIN_ALMOST_WR_MARGIN),
                        n == '0,
                        n <= (AW+1)'(`DRAIN_ALMOST_RD_MARGIN)};
        endfunction

        task automatic abort_run(input string reason);
                $display("%s", reason);
                $display("Test failures found");
                $fatal(1, "Stopped at first error");
        endtask

        task automatic report_mismatch(input string test, input logic [63:0] expected,
                                       input logic [63:0] actual);
                abort_run($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h",
                                    test, expected, actual));
        endtask

        // ------------------------------
        // Reference model
        // ------------------------------
        // DUT registers take reset values on the first edge with reset low
        always @(posedge axi_aclk) begin
                if (!arst_n) begin
                        reset_seen <= 1'b1;
                end
        end

        always @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        exp_avail     <= '0;
                        exp_stored    <= '0;
                        exp_remaining <= '0;
                        exp_head      <= '0;
                        accept_count  <= '0;
                        stall_prev    <= 1'b0;
                        beat_prev     <= '0;
                        saw_full      <= 1'b0;
                        accepted_q.delete();
                end else begin : model_step
                        logic        acc;
                        logic        xfer;
                        logic [AW:0] reserve;
                        acc     = in_valid && in_ready;
                        xfer    = out_valid && out_ready;
                        reserve = cmd_valid ? (AW+1)'(cmd.len) : '0;
                        if (acc) begin
                                accepted_q.push_back(in_beat.data);
                                accept_count <= accept_count + 1'b1;   // Data counts up per beat
                        end
                        if (xfer && accepted_q.size() > 0) begin
                                void'(accepted_q.pop_front());
                        end
                        exp_head   <= (accepted_q.size() > 0) ? accepted_q[0] : '0;
                        exp_avail  <= exp_avail + (AW+1)'(acc) - reserve;
                        exp_stored <= exp_stored + (AW+1)'(acc) - (AW+1)'(xfer);
                        if (cmd_valid) begin
                                exp_remaining <= cmd.len;               // Burst opens
                        end else if (xfer) begin
                                exp_remaining <= exp_remaining - 1'b1;
                        end
                        stall_prev <= out_valid && !out_ready;
                        beat_prev  <= out_beat;
                        if (!in_ready) begin
                                saw_full <= 1'b1;
                        end
                end
        end

        // ------------------------------
        // Checks
        // ------------------------------
        logic [11:0] reset_view;
        logic [11:0] reset_expect;
        logic        cmd_allowed;
        assign reset_view   = {out_valid, cmd_valid, in_ready, status};
        assign reset_expect = {3'b001, {(AW+1){1'b0}}, flags_for('0)};
        assign cmd_allowed  = (LW'(exp_avail) >= burst_len) && (exp_remaining == '0);

        a_reset: assert property (@(posedge axi_aclk)
                arst_n || !reset_seen || reset_view == reset_expect)
                else report_mismatch("reset_state", 64'(reset_expect), 64'(reset_view));
        a_avail: assert property (@(posedge axi_aclk) disable iff (!arst_n)
                status.data_available == exp_avail)
                else report_mismatch("occupancy", 64'(exp_avail), 64'(status.data_available));
        a_flags: assert property (@(posedge axi_aclk) disable iff (!arst_n)
                status[3:0] == flags_for(exp_avail))
                else report_mismatch("status_flags", 64'(flags_for(exp_avail)), 64'(status[3:0]));
        a_in_ready: assert property (@(posedge axi_aclk) disable iff (!arst_n)
                in_ready == (exp_stored != (AW+1)'(`DRAIN_DEPTH)))
                else report_mismatch("in_ready", 64'(exp_stored != (AW+1)'(`DRAIN_DEPTH)),
                                     64'(in_ready));
        a_gate: assert property (@(posedge axi_aclk) disable iff (!arst_n)
                cmd_valid == cmd_allowed)
                else report_mismatch("cmd_gating", 64'(cmd_allowed), 64'(cmd_valid));
        a_len: assert property (@(posedge axi_aclk) disable iff (!arst_n)
                !cmd_valid || cmd.len == burst_len)
                else report_mismatch("cmd_len", 64'(burst_len), 64'(cmd.len));
        a_valid: assert property (@(posedge axi_aclk) disable iff (!arst_n)
                out_valid == (exp_remaining != '0))
                else report_mismatch("beat_count", 64'(exp_remaining != '0), 64'(out_valid));
        a_last: assert property (@(posedge axi_aclk) disable iff (!arst_n)
                out_last == (out_valid && exp_remaining == LW'(1)))
                else report_mismatch("out_last", 64'(out_valid && exp_remaining == LW'(1)),
                                     64'(out_last));
        a_data: assert property (@(posedge axi_aclk) disable iff (!arst_n)
                !(out_valid && out_ready) || out_beat.data == exp_head)
                else report_mismatch("beat_data", 64'(exp_head), 64'(out_beat.data));
        a_hold: assert property (@(posedge axi_aclk) disable iff (!arst_n)
                !stall_prev || (out_valid && out_beat == beat_prev))
                else report_mismatch("backpressure_hold", 64'(beat_prev), 64'(out_beat));

        // ------------------------------
        // Stimulus
        // ------------------------------
        task automatic run_phase(input int len, input int cycles, input int valid_pct,
                                 input int ready_pct);
                logic hit;
                burst_len = LW'(len);                   // Only changed while idle
                repeat (cycles) begin
                        roll_percent(valid_pct, hit);
                        in_valid     = hit;
                        in_beat.data = accept_count;
                        roll_percent(ready_pct, hit);
                        out_ready    = hit;
                        @(negedge axi_aclk);
                end
        endtask

        // Stop input and let open bursts finish
        task automatic settle_idle();
                in_valid  = 1'b0;
                out_ready = 1'b1;
                @(negedge axi_aclk);
                while (out_valid || cmd_valid) begin
                        @(negedge axi_aclk);
                end
        endtask

        initial begin
                arst_n    = 1'b0;
                burst_len = LW'(1);
                in_valid  = 1'b0;
                in_beat   = '0;
                out_ready = 1'b0;
                repeat (10) @(negedge axi_aclk);
                arst_n = 1'b1;
                run_phase(1, PHASE_CYCLES, 60, 70);
                settle_idle();
                run_phase(4, PHASE_CYCLES, 60, 70);
                settle_idle();
                run_phase(`DRAIN_BURST_MAX, PHASE_CYCLES, 70, 60);
                settle_idle();
                run_phase(4, BP_CYCLES, 100, 0);        // Fill the buffer
                run_phase(4, PHASE_CYCLES, 50, 80);     // Then drain it
                settle_idle();
                burst_len = LW'(1);                     // Flush leftovers
                settle_idle();
                if (!saw_full) begin
                        abort_run("Buffer never filled during the back-pressure phase");
                end else begin
                        $display("All tests passed!");
                        $finish;
                end
        end

        initial begin
                #(WATCHDOG_TIME);
                abort_run("Timeout: the run did not finish within the expected time");
        end

endmodule : tb_stream_drain

// File: rtl/stream_drain_top.sv
`include "stream_drain_consts.svh"

module stream_drain_top
        import stream_drain_pkg::*;
(
        input  logic                    axi_aclk,
        input  logic                    arst_n,
        input  logic [`DRAIN_LEN_W-1:0] burst_len,
        input  logic                    in_valid,
        input  beat_t                   in_beat,
        output logic                    in_ready,
        output logic                    cmd_valid,
        output burst_cmd_t              cmd,
        output logic                    out_valid,
        output beat_t                   out_beat,
        output logic                    out_last,
        input  logic                    out_ready,
        output drain_status_t           status
);

        // ------------------------------
        // Internal wiring
        // ------------------------------
        logic                    push;
        logic                    pop;
        beat_t                   head;
        logic                    drain_valid;
        logic [`DRAIN_LEN_W-1:0] drain_size;

        beat_buffer u_beat_buffer (
                .axi_aclk (axi_aclk),
                .arst_n   (arst_n),
                .in_valid (in_valid),
                .in_beat  (in_beat),
                .in_ready (in_ready),
                .push     (push),
                .pop      (pop),
                .head     (head)
        );

        // Virtual FIFO mirrors buffer writes, drains by reservation
        stream_drain_ctrl u_drain_ctrl (
                .axi_aclk    (axi_aclk),
                .arst_n      (arst_n),
                .wr_push     (push),
                .drain_valid (drain_valid),
                .drain_size  (drain_size),
                .drain_ready (),                // Issuer gates on data_available
                .status      (status)
        );

        burst_issuer u_burst_issuer (
                .axi_aclk    (axi_aclk),
                .arst_n      (arst_n),
                .burst_len   (burst_len),
                .status      (status),
                .drain_valid (drain_valid),
                .drain_size  (drain_size),
                .cmd_valid   (cmd_valid),
                .cmd         (cmd),
                .head        (head),
                .pop         (pop),
                .out_valid   (out_valid),
                .out_beat    (out_beat),
                .out_last    (out_last),
                .out_ready   (out_ready)
        );

endmodule : stream_drain_top

// File: rtl/burst_issuer.sv
`include "stream_drain_consts.svh"

module burst_issuer
        import stream_drain_pkg::*;
(
        input  logic                    axi_aclk,
        input  logic                    arst_n,
        input  logic [`DRAIN_LEN_W-1:0] burst_len,      // Quasi-static
        input  drain_status_t           status,
        output logic                    drain_valid,    // Reserve pulse
        output logic [`DRAIN_LEN_W-1:0] drain_size,
        output logic                    cmd_valid,      // Command pulse
        output burst_cmd_t              cmd,
        input  beat_t                   head,
        output logic                    pop,
        output logic                    out_valid,
        output beat_t                   out_beat,
        output logic                    out_last,
        input  logic                    out_ready
);

        localparam int LEN_W = `DRAIN_LEN_W;

        typedef enum logic {
                ST_IDLE,
                ST_STREAM
        } state_t;

        state_t           state;
        logic [LEN_W-1:0] remaining;    // Beats left in open burst
        logic             len_ok;
        logic             enough;
        logic             launch;
        logic             xfer;

        // ------------------------------
        // Launch decision
        // ------------------------------
        // Zero or oversize lengths never start a burst
        assign len_ok = (burst_len != '0) && (burst_len <= LEN_W'(`DRAIN_BURST_MAX));
        assign enough = LEN_W'(status.data_available) >= burst_len;
        assign launch = (state == ST_IDLE) && len_ok && enough;

        // Reserve and command in the same cycle
        assign drain_valid = launch;
        assign drain_size  = burst_len;
        assign cmd_valid   = launch;
        assign cmd.len     = burst_len;

        // ------------------------------
        // Beat streaming
        // ------------------------------
        assign out_valid = (state == ST_STREAM);
        assign out_beat  = head;                        // Stable until popped
        assign out_last  = out_valid && (remaining == LEN_W'(1));
        assign xfer      = out_valid && out_ready;
        assign pop       = xfer;                        // Pop on the transfer edge

        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        state     <= ST_IDLE;
                        remaining <= '0;
                end else begin
                        case (state)
                                ST_IDLE: begin
                                        if (launch) begin
                                                state     <= ST_STREAM;
                                                remaining <= burst_len;
                                        end
                                end
                                ST_STREAM: begin
                                        if (xfer) begin
                                                remaining <= remaining - 1'b1;
                                                if (remaining == LEN_W'(1)) begin
                                                        state <= ST_IDLE; // Last beat out
                                                end
                                        end
                                end
                                default: state <= ST_IDLE;
                        endcase
                end
        end

endmodule : burst_issuer

// File: rtl/beat_buffer.sv
`include "stream_drain_consts.svh"

module beat_buffer
        import stream_drain_pkg::*;
(
        input  logic    axi_aclk,
        input  logic    arst_n,
        input  logic    in_valid,
        input  beat_t   in_beat,
        output logic    in_ready,       // Not full
        output logic    push,           // Strobe per accepted beat
        input  logic    pop,            // Consume head
        output beat_t   head            // Oldest stored beat
);

        localparam int AW = $clog2(`DRAIN_DEPTH);

        beat_t       mem [`DRAIN_DEPTH];
        logic [AW:0] wr_ptr;
        logic [AW:0] rd_ptr;
        logic        full;

        // ------------------------------
        // Flags
        // ------------------------------
        // Same index, opposite lap bit
        assign full = (wr_ptr[AW] != rd_ptr[AW]) &&
                      (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

        assign in_ready = !full;
        assign push     = in_valid && in_ready;

        // ------------------------------
        // Pointers
        // ------------------------------
        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (push) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        // Issuer pops only reserved beats, never from empty
                        if (pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                end
        end

        // Storage, no reset needed on payload
        always_ff @(posedge axi_aclk) begin
                if (push) begin
                        mem[wr_ptr[AW-1:0]] <= in_beat;
                end
        end

        // Read is combinational off the read pointer
        assign head = mem[rd_ptr[AW-1:0]];

endmodule : beat_buffer

// File: rtl/stream_drain_ctrl.sv
`include "stream_drain_consts.svh"

module stream_drain_ctrl
        import stream_drain_pkg::*;
(
        input  logic                           axi_aclk,
        input  logic                           arst_n,
        input  logic                           wr_push,         // One beat entered the buffer
        input  logic                           drain_valid,     // Reservation pulse
        input  logic [`DRAIN_LEN_W-1:0]        drain_size,      // Beats to reserve
        output logic                           drain_ready,
        output drain_status_t                  status
);

        localparam int AW = $clog2(`DRAIN_DEPTH);

        logic [AW:0] wr_ptr_next;
        logic [AW:0] rd_ptr;
        logic [AW:0] rd_ptr_next;
        logic        drain_take;

        // ------------------------------
        // Write side
        // ------------------------------
        // Occupancy comes from the next pointers only
        counter_bin u_wr_ptr (
                .axi_aclk   (axi_aclk),
                .arst_n     (arst_n),
                .enable     (wr_push),
                .count_curr (),
                .count_next (wr_ptr_next)
        );

        // ------------------------------
        // Drain side with variable step
        // ------------------------------
        // Issuer only asks when enough beats exist
        assign drain_take  = drain_valid && drain_ready;
        assign rd_ptr_next = rd_ptr + (drain_take ? (AW+1)'(drain_size) : '0);

        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        rd_ptr <= '0;
                end else begin
                        rd_ptr <= rd_ptr_next;  // Wraps naturally at 2*depth
                end
        end

        // Count and flags from the post-edge pointers
        fifo_control u_fifo_control (
                .axi_aclk    (axi_aclk),
                .arst_n      (arst_n),
                .wr_ptr_next (wr_ptr_next),
                .rd_ptr_next (rd_ptr_next),
                .status      (status)
        );

        // Polled level rather than a handshake
        assign drain_ready = !status.empty;

endmodule : stream_drain_ctrl

// File: rtl/fifo_control.sv
`include "stream_drain_consts.svh"

module fifo_control
        import stream_drain_pkg::*;
(
        input  logic                           axi_aclk,
        input  logic                           arst_n,
        input  logic [$clog2(`DRAIN_DEPTH):0]  wr_ptr_next,     // Post-edge write pointer
        input  logic [$clog2(`DRAIN_DEPTH):0]  rd_ptr_next,     // Post-edge read pointer
        output drain_status_t                  status
);

        localparam int AW = $clog2(`DRAIN_DEPTH);

        // ------------------------------
        // Flag thresholds
        // ------------------------------
        localparam logic [AW:0] FULL_LVL   = (AW+1)'(`DRAIN_DEPTH);
        localparam logic [AW:0] AFULL_LVL  = (AW+1)'(`DRAIN_DEPTH - `DRAIN_ALMOST_WR_MARGIN);
        localparam logic [AW:0] AEMPTY_LVL = (AW+1)'(`DRAIN_ALMOST_RD_MARGIN);

        logic [AW:0] count_next;

        // Modular difference, the MSB handles pointer wrap
        assign count_next = wr_ptr_next - rd_ptr_next;

        // Flags registered from the next count, so status is the post-edge state
        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        status.data_available <= '0;
                        status.full           <= 1'b0;
                        status.almost_full    <= 1'b0;
                        status.empty          <= 1'b1;  // Nothing stored out of reset
                        status.almost_empty   <= 1'b1;
                end else begin
                        status.data_available <= count_next;
                        status.full           <= (count_next == FULL_LVL);
                        status.almost_full    <= (count_next >= AFULL_LVL);
                        status.empty          <= (count_next == '0);
                        status.almost_empty   <= (count_next <= AEMPTY_LVL);
                end
        end

endmodule : fifo_control

// File: rtl/counter_bin.sv
`include "stream_drain_consts.svh"

module counter_bin (
        input  logic                           axi_aclk,
        input  logic                           arst_n,
        input  logic                           enable,
        output logic [$clog2(`DRAIN_DEPTH):0]  count_curr,
        output logic [$clog2(`DRAIN_DEPTH):0]  count_next
);

        localparam int AW = $clog2(`DRAIN_DEPTH);
        // Extra MSB separates full from empty, so wrap at twice the depth
        localparam logic [AW:0] LAST = (AW+1)'(2 * `DRAIN_DEPTH - 1);

        // Value the register takes at the coming edge
        always_comb begin
                if (!enable) begin
                        count_next = count_curr;        // Hold
                end else if (count_curr == LAST) begin
                        count_next = '0;                // Wrap
                end else begin
                        count_next = count_curr + 1'b1;
                end
        end

        always_ff @(posedge axi_aclk or negedge arst_n) begin
                if (!arst_n) begin
                        count_curr <= '0;
                end else begin
                        count_curr <= count_next;
                end
        end

endmodule : counter_bin

// File: rtl/stream_drain_pkg.sv
`include "stream_drain_consts.svh"

package stream_drain_pkg;

        // ------------------------------
        // Payload
        // ------------------------------
        typedef struct packed {
                logic [`DRAIN_DATA_W-1:0] data;         // One stream word
        } beat_t;

        // Burst command, address phase only
        typedef struct packed {
                logic [`DRAIN_LEN_W-1:0] len;           // Beats in burst, 1..BURST_MAX
        } burst_cmd_t;

        // ------------------------------
        // Virtual FIFO status
        // ------------------------------
        typedef struct packed {
                logic [$clog2(`DRAIN_DEPTH):0] data_available; // Unreserved beats
                logic                          full;
                logic                          almost_full;
                logic                          empty;
                logic                          almost_empty;
        } drain_status_t;

endpackage : stream_drain_pkg

// File: rtl/stream_drain_consts.svh
`ifndef STREAM_DRAIN_CONSTS_SVH
`define STREAM_DRAIN_CONSTS_SVH

// ------------------------------
// Buffer geometry
// ------------------------------
`define DRAIN_DEPTH             16      // Entries, power of two
`define DRAIN_ALMOST_WR_MARGIN  2       // Almost-full margin
`define DRAIN_ALMOST_RD_MARGIN  2       // Almost-empty margin

// Payload and burst sizing
`define DRAIN_DATA_W            32
`define DRAIN_BURST_MAX         8       // Longest burst in beats
`define DRAIN_LEN_W             8       // Same width as the drain size field

`endif
